/* hdl/niu_defines.svh */
`ifndef NIU_DEFINES_SVH
`define NIU_DEFINES_SVH

// Datapath and bus width
`define NIU_WORD 32

// Instruction field widths
`define NIU_REG_BITS 5
`define NIU_IMM_BITS 17
`define NIU_OP_BITS 5

// Byte step between instruction words
`define NIU_INSTR_STEP 4

// First fetch address out of reset
`define NIU_PC_START 32'h0000_0000

`endif

/* hdl/niuPkg.sv */
`include "niu_defines.svh"

package niuPkg;

    // Primary opcodes, instr[31:27]
    typedef enum logic [`NIU_OP_BITS-1:0] {
        OP1_ALUR = 5'b00000, // Register form, function in op2
        OP1_ADDI = 5'b00001,
        OP1_ANDI = 5'b00101,
        OP1_ORI  = 5'b00110,
        OP1_XORI = 5'b00111,
        OP1_SULI = 5'b01000,
        OP1_SSLI = 5'b01001,
        OP1_SURI = 5'b01010,
        OP1_SSRI = 5'b01011,
        OP1_LW   = 5'b10000,
        OP1_SW   = 5'b10011,
        OP1_BEQ  = 5'b11000,
        OP1_BNE  = 5'b11001,
        OP1_BLT  = 5'b11010,
        OP1_BLE  = 5'b11011,
        OP1_JAL  = 5'b11111
    } op1T;

    // Secondary function, instr[4:0] for register form
    // Immediate opcodes share these codes with their function
    typedef enum logic [`NIU_OP_BITS-1:0] {
        ALU_SUB = 5'b00000,
        ALU_ADD = 5'b00001,
        ALU_NOT = 5'b00100,
        ALU_AND = 5'b00101,
        ALU_OR  = 5'b00110,
        ALU_XOR = 5'b00111,
        ALU_SUL = 5'b01000, // Unsigned shift left
        ALU_SSL = 5'b01001,
        ALU_SUR = 5'b01010, // Logical shift right
        ALU_SSR = 5'b01011, // Arithmetic shift right
        ALU_EQ  = 5'b10000,
        ALU_NEQ = 5'b10001,
        ALU_LT  = 5'b10010,
        ALU_LEQ = 5'b10011
    } aluFuncT;

    typedef struct packed {
        op1T                     op1;
        logic [`NIU_REG_BITS-1:0] rx;
        logic [`NIU_REG_BITS-1:0] ry;
        logic [`NIU_REG_BITS-1:0] rz;
        logic [`NIU_WORD-1:0]     imm; // Already sign-extended
        aluFuncT                 op2;
    } decodedT;

    typedef enum logic [2:0] {
        FETCH,
        DECODE,
        EXEC,
        MEM,
        BRANCH,
        JUMP,
        HALT
    } ctrlStateT;

    // Register writeback source
    typedef enum logic [1:0] {
        WB_ALU,
        WB_LOAD,
        WB_LINK
    } wrSelT;

endpackage

/* hdl/niuIf.sv */
`include "niu_defines.svh"

// Instruction fetch request and decoded result
interface fetchIf;
    import niuPkg::*;

    logic                 req;   // One-cycle pulse
    logic [`NIU_WORD-1:0] pc;
    logic                 done;  // Cycle after iAck
    decodedT              instr; // Held until next req

    modport control (output req, input done, input instr);
    modport datapath (output pc, input instr);
    modport fetch (input req, input pc, output done, output instr);
endinterface

// Data load and store request
interface memIf;
    logic                 req;
    logic                 we;
    logic [`NIU_WORD-1:0] addr;
    logic [`NIU_WORD-1:0] wdata;
    logic [`NIU_WORD-1:0] rdata; // Valid with done
    logic                 done;

    modport control (output req, output we, input done);
    modport datapath (output addr, output wdata, input rdata);
    modport loadStore (input req, input we, input addr, input wdata, output rdata, output done);
endinterface

/* hdl/instrFetch.sv */
`include "niu_defines.svh"

module instrFetch (
    input  logic                 clk,
    input  logic                 reset,
    fetchIf.fetch                fetch,
    output logic                 iCyc,
    output logic                 iStb,
    output logic [`NIU_WORD-1:0] iAdr,
    input  logic [`NIU_WORD-1:0] iDatI,
    input  logic                 iAck
);
    import niuPkg::*;

    // Field positions, op1 at the top of the word
    localparam int OpLsb = `NIU_WORD - `NIU_OP_BITS;
    localparam int RxLsb = OpLsb - `NIU_REG_BITS;
    localparam int RyLsb = RxLsb - `NIU_REG_BITS;
    localparam int RzLsb = RyLsb - `NIU_REG_BITS;

    logic [`NIU_WORD-1:0] ir;
    decodedT              dec;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            iCyc       <= 1'b0;
            iStb       <= 1'b0;
            fetch.done <= 1'b0;
        end else begin
            fetch.done <= 1'b0;
            if (fetch.req) begin
                iCyc <= 1'b1;
                iStb <= 1'b1;
            end else if (iCyc && iAck) begin
                iCyc       <= 1'b0; // Drop in the cycle after ack
                iStb       <= 1'b0;
                fetch.done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetch.req) begin
            iAdr <= fetch.pc;
        end
        if (iCyc && iAck) begin
            ir <= iDatI;
        end
    end

    always_comb begin
        dec.op1 = op1T'(ir[`NIU_WORD-1:OpLsb]);
        dec.rx  = ir[OpLsb-1:RxLsb];
        dec.ry  = ir[RxLsb-1:RyLsb];
        dec.rz  = ir[RyLsb-1:RzLsb];
        dec.imm = {{(`NIU_WORD - `NIU_IMM_BITS){ir[`NIU_IMM_BITS-1]}}, ir[`NIU_IMM_BITS-1:0]};
        dec.op2 = aluFuncT'(ir[`NIU_OP_BITS-1:0]);
    end

    assign fetch.instr = dec;

endmodule

/* hdl/niuAlu.sv */
`include "niu_defines.svh"

module niuAlu (
    input  niuPkg::aluFuncT             func,
    input  logic signed [`NIU_WORD-1:0] a,
    input  logic signed [`NIU_WORD-1:0] b,
    output logic signed [`NIU_WORD-1:0] y
);
    import niuPkg::*;

    localparam logic signed [`NIU_WORD-1:0] One = 1;

    logic [$clog2(`NIU_WORD)-1:0] shamt;

    assign shamt = b[$clog2(`NIU_WORD)-1:0]; // Low bits only

    always_comb begin
        case (func)
            ALU_SUB: y = a - b;
            ALU_ADD: y = a + b;
            ALU_NOT: y = ~a;
            ALU_AND: y = a & b;
            ALU_OR:  y = a | b;
            ALU_XOR: y = a ^ b;
            ALU_SUL: y = a << shamt;
            ALU_SSL: y = a <<< shamt;
            ALU_SUR: y = a >> shamt;
            ALU_SSR: y = a >>> shamt; // Sign fill
            // Signed compares give 1 or 0
            ALU_EQ:  y = (a == b) ? One : '0;
            ALU_NEQ: y = (a != b) ? One : '0;
            ALU_LT:  y = (a < b) ? One : '0;
            ALU_LEQ: y = (a <= b) ? One : '0;
            default: y = '0;
        endcase
    end

endmodule

/* hdl/niuDatapath.sv */
`include "niu_defines.svh"

module niuDatapath (
    input  logic            clk,
    input  logic            reset,
    fetchIf.datapath        fetch,
    memIf.datapath          mem,
    input  logic            loadOps,
    input  logic            wrEn,
    input  niuPkg::wrSelT   wrSel,
    input  logic            incPc,
    input  logic            ldPcBranch,
    input  logic            ldPcJump,
    input  niuPkg::aluFuncT aluFunc,
    output logic            taken
);
    import niuPkg::*;

    logic [`NIU_WORD-1:0]        pc;
    logic [`NIU_WORD-1:0]        regs [0:(1 << `NIU_REG_BITS) - 1];
    logic [`NIU_WORD-1:0]        rxVal, ryVal, wrData;
    logic [`NIU_REG_BITS-1:0]    dest;
    logic signed [`NIU_WORD-1:0] opA, opB, aluY;
    logic                        useRy;

    // r0 always reads as zero
    assign rxVal = (fetch.instr.rx == '0) ? '0 : regs[fetch.instr.rx];
    assign ryVal = (fetch.instr.ry == '0) ? '0 : regs[fetch.instr.ry];

    assign useRy = fetch.instr.op1 inside {OP1_ALUR, OP1_BEQ, OP1_BNE, OP1_BLT, OP1_BLE};
    assign dest  = (fetch.instr.op1 == OP1_ALUR) ? fetch.instr.rz : fetch.instr.ry;

    always_ff @(posedge clk) begin
        if (loadOps) begin
            opA <= rxVal;
            opB <= useRy ? ryVal : fetch.instr.imm;
        end
    end

    niuAlu alu (.func(aluFunc), .a(opA), .b(opB), .y(aluY));

    always_comb begin
        case (wrSel)
            WB_LOAD: wrData = mem.rdata;
            WB_LINK: wrData = pc; // Already points past the JAL
            default: wrData = aluY;
        endcase
    end

    always_ff @(posedge clk) begin
        if (wrEn) begin
            regs[dest] <= wrData;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= `NIU_PC_START;
        end else if (ldPcJump) begin
            pc <= opA;
        end else if (ldPcBranch) begin
            pc <= pc + {fetch.instr.imm[`NIU_WORD-3:0], 2'b00}; // Word offset
        end else if (incPc) begin
            pc <= pc + `NIU_INSTR_STEP;
        end
    end

    assign fetch.pc  = pc;
    assign mem.addr  = aluY;  // rx + imm
    assign mem.wdata = ryVal;
    assign taken     = aluY[0];

endmodule

/* hdl/niuControl.sv */
module niuControl (
    input  logic             clk,
    input  logic             reset,
    fetchIf.control          fetch,
    memIf.control            mem,
    output logic             loadOps,
    output logic             wrEn,
    output niuPkg::wrSelT    wrSel,
    output logic             incPc,
    output logic             ldPcBranch,
    output logic             ldPcJump,
    output niuPkg::aluFuncT  aluFunc,
    input  logic             taken
);
    import niuPkg::*;

    ctrlStateT state, nextState;
    logic      waiting; // Fetch issued, done not yet seen
    op1T       op1;

    assign op1   = fetch.instr.op1;
    assign incPc = fetch.done;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state   <= FETCH;
            waiting <= 1'b0;
        end else begin
            state <= nextState;
            if (fetch.req) begin
                waiting <= 1'b1;
            end else if (fetch.done) begin
                waiting <= 1'b0;
            end
        end
    end

    // ALU function from the instruction
    always_comb begin
        case (op1)
            OP1_ALUR: aluFunc = fetch.instr.op2;
            OP1_ADDI, OP1_ANDI, OP1_ORI, OP1_XORI,
            OP1_SULI, OP1_SSLI, OP1_SURI, OP1_SSRI: aluFunc = aluFuncT'(op1);
            OP1_BEQ: aluFunc = ALU_EQ;
            OP1_BNE: aluFunc = ALU_NEQ;
            OP1_BLT: aluFunc = ALU_LT;
            OP1_BLE: aluFunc = ALU_LEQ;
            default: aluFunc = ALU_ADD; // Address for LW and SW
        endcase
    end

    always_comb begin
        nextState  = state;
        fetch.req  = 1'b0;
        mem.req    = 1'b0;
        mem.we     = 1'b0;
        loadOps    = 1'b0;
        wrEn       = 1'b0;
        wrSel      = WB_ALU;
        ldPcBranch = 1'b0;
        ldPcJump   = 1'b0;
        case (state)
            FETCH: begin
                fetch.req = !waiting;
                if (fetch.done) nextState = DECODE;
            end
            DECODE: begin
                loadOps = 1'b1; // rx and ry/imm into the operand registers
                case (op1)
                    OP1_ALUR, OP1_ADDI, OP1_ANDI, OP1_ORI, OP1_XORI,
                    OP1_SULI, OP1_SSLI, OP1_SURI, OP1_SSRI,
                    OP1_LW, OP1_SW, OP1_BEQ, OP1_BNE, OP1_BLT, OP1_BLE,
                    OP1_JAL: nextState = EXEC;
                    default: nextState = HALT;
                endcase
            end
            EXEC: begin
                case (op1)
                    OP1_LW, OP1_SW: begin
                        mem.req   = 1'b1;
                        mem.we    = (op1 == OP1_SW);
                        nextState = MEM;
                    end
                    OP1_BEQ, OP1_BNE, OP1_BLT, OP1_BLE: nextState = taken ? BRANCH : FETCH;
                    OP1_JAL: nextState = JUMP;
                    default: begin
                        wrEn      = 1'b1;
                        nextState = FETCH;
                    end
                endcase
            end
            MEM: begin
                if (mem.done) begin
                    wrEn      = (op1 == OP1_LW);
                    wrSel     = WB_LOAD;
                    nextState = FETCH;
                end
            end
            BRANCH: begin
                ldPcBranch = 1'b1;
                nextState  = FETCH;
            end
            JUMP: begin
                wrEn      = 1'b1; // Link into ry
                wrSel     = WB_LINK;
                ldPcJump  = 1'b1;
                nextState = FETCH;
            end
            HALT: nextState = HALT;
            default: nextState = HALT;
        endcase
    end

endmodule

/* hdl/loadStore.sv */
`include "niu_defines.svh"

module loadStore (
    input  logic                 clk,
    input  logic                 reset,
    memIf.loadStore              mem,
    output logic                 dCyc,
    output logic                 dStb,
    output logic                 dWe,
    output logic [`NIU_WORD-1:0] dAdr,
    output logic [`NIU_WORD-1:0] dDatO,
    input  logic [`NIU_WORD-1:0] dDatI,
    input  logic                 dAck
);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            dCyc     <= 1'b0;
            dStb     <= 1'b0;
            dWe      <= 1'b0;
            mem.done <= 1'b0;
        end else begin
            mem.done <= 1'b0;
            if (mem.req) begin
                dCyc <= 1'b1;
                dStb <= 1'b1;
                dWe  <= mem.we; // Held for the whole cycle
            end else if (dCyc && dAck) begin
                dCyc     <= 1'b0;
                dStb     <= 1'b0;
                dWe      <= 1'b0;
                mem.done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mem.req) begin
            dAdr  <= mem.addr;
            dDatO <= mem.wdata;
        end
        if (dCyc && dAck) begin
            mem.rdata <= dDatI; // Don't care on stores
        end
    end

endmodule

/* hdl/niuCore.sv */
`include "niu_defines.svh"

module niuCore (
    input  logic                 clk,
    input  logic                 reset,
    // Instruction master
    output logic                 iCyc,
    output logic                 iStb,
    output logic [`NIU_WORD-1:0] iAdr,
    input  logic [`NIU_WORD-1:0] iDatI,
    input  logic                 iAck,
    // Data master
    output logic                 dCyc,
    output logic                 dStb,
    output logic                 dWe,
    output logic [`NIU_WORD-1:0] dAdr,
    output logic [`NIU_WORD-1:0] dDatO,
    input  logic [`NIU_WORD-1:0] dDatI,
    input  logic                 dAck
);
    import niuPkg::*;

    fetchIf fetchBus ();
    memIf   memBus ();

    logic    loadOps, wrEn, incPc, ldPcBranch, ldPcJump, taken;
    wrSelT   wrSel;
    aluFuncT aluFunc;

    instrFetch fetchUnit (
        .clk(clk), .reset(reset), .fetch(fetchBus),
        .iCyc(iCyc), .iStb(iStb), .iAdr(iAdr), .iDatI(iDatI), .iAck(iAck)
    );

    niuControl control (
        .clk(clk), .reset(reset), .fetch(fetchBus), .mem(memBus),
        .loadOps(loadOps), .wrEn(wrEn), .wrSel(wrSel), .incPc(incPc),
        .ldPcBranch(ldPcBranch), .ldPcJump(ldPcJump), .aluFunc(aluFunc), .taken(taken)
    );

    niuDatapath datapath (
        .clk(clk), .reset(reset), .fetch(fetchBus), .mem(memBus),
        .loadOps(loadOps), .wrEn(wrEn), .wrSel(wrSel), .incPc(incPc),
        .ldPcBranch(ldPcBranch), .ldPcJump(ldPcJump), .aluFunc(aluFunc), .taken(taken)
    );

    loadStore dataUnit (
        .clk(clk), .reset(reset), .mem(memBus),
        .dCyc(dCyc), .dStb(dStb), .dWe(dWe), .dAdr(dAdr), .dDatO(dDatO),
        .dDatI(dDatI), .dAck(dAck)
    );

endmodule

/* tb/niuCore_chk.sv */
`include "niu_defines.svh"

module niuCoreChk (
    input logic                 clk,
    input logic                 reset,
    input logic                 iCyc,
    input logic                 iStb,
    input logic                 iAck,
    input logic [`NIU_WORD-1:0] iAdr,
    input logic                 dCyc,
    input logic                 dStb,
    input logic                 dWe,
    input logic                 dAck,
    input logic [`NIU_WORD-1:0] dAdr,
    input logic [`NIU_WORD-1:0] dDatO
);
    timeunit 1ns;
    timeprecision 100ps;

    logic seenFetch; // Set once the first instruction cycle is out

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            seenFetch <= 1'b0;
        end else if (iCyc) begin
            seenFetch <= 1'b1;
        end
    end

    resetQuiet: assert property (@(posedge clk) reset |-> !iCyc && !iStb && !dCyc && !dStb && !dWe)
        else $error("Bus active during reset");

    // First fetch in the second cycle after reset
    firstFetchTime: assert property (@(posedge clk) $fell(reset) |-> !iCyc && !dCyc ##1 iCyc)
        else $error("First fetch not in the second cycle after reset");

    firstFetchAdr: assert property (@(posedge clk) disable iff (reset)
        (iCyc && !seenFetch) |-> iAdr == `NIU_PC_START)
        else $error("First fetch address is not the reset PC");

    stbInCyc: assert property (@(posedge clk) disable iff (reset) (iStb |-> iCyc) and (dStb |-> dCyc))
        else $error("Strobe without cycle");

    instrStable: assert property (@(posedge clk) disable iff (reset)
        iStb && !iAck |=> iStb && $stable(iAdr))
        else $error("Instruction address changed before ack");

    dataStable: assert property (@(posedge clk) disable iff (reset)
        dStb && !dAck |=> dStb && $stable(dAdr) && $stable(dWe) && $stable(dDatO))
        else $error("Data cycle changed before ack");

endmodule

bind niuCore niuCoreChk chk (
    .clk(clk), .reset(reset), .iCyc(iCyc), .iStb(iStb), .iAck(iAck), .iAdr(iAdr),
    .dCyc(dCyc), .dStb(dStb), .dWe(dWe), .dAck(dAck), .dAdr(dAdr), .dDatO(dDatO)
);

/* tb/niuCoreTb.sv */
`include "niu_defines.svh"

module niuCoreTb;
    timeunit 1ns;
    timeprecision 100ps;

    // Opcodes and function codes of the instruction set
    localparam int OpAlur = 0;
    localparam int OpAddi = 1;
    localparam int OpBad  = 2; // Not an opcode, core must halt
    localparam int OpLw   = 16;
    localparam int OpSw   = 19;
    localparam int OpBeq  = 24;
    localparam int OpBne  = 25;
    localparam int OpBlt  = 26;
    localparam int OpBle  = 27;
    localparam int OpJal  = 31;

    localparam int FSub = 0;
    localparam int FAdd = 1;
    localparam int FNot = 4;
    localparam int FAnd = 5;
    localparam int FOr  = 6;
    localparam int FXor = 7;
    localparam int FSul = 8;
    localparam int FSsl = 9;
    localparam int FSur = 10;
    localparam int FSsr = 11;
    localparam int FEq  = 16;
    localparam int FNeq = 17;
    localparam int FLt  = 18;
    localparam int FLeq = 19;

    localparam int ProgMax = 128;

    // Register contents set up by the first four instructions
    localparam logic signed [31:0] R1 = -32'sd100;
    localparam logic signed [31:0] R2 = 32'sd7;
    localparam logic signed [31:0] R3 = 32'sh55;
    localparam logic signed [31:0] R4 = 32'sh200; // Store base

    logic                 clk, reset;
    logic                 iCyc, iStb, iAck, dCyc, dStb, dWe, dAck;
    logic [`NIU_WORD-1:0] iAdr, iDatI, dAdr, dDatO, dDatI;

    logic [31:0] prog [0:ProgMax-1];
    logic [31:0] dmem [logic [31:0]];
    string       expName [$];
    logic [31:0] expAdr [$];
    logic [31:0] expDat [$];
    logic [31:0] haltAdr;
    logic        haltSeen;
    logic        built;
    int          progLen;
    int          seed = 32'hd4da9565;

    niuCore DUT (
        .clk(clk), .reset(reset),
        .iCyc(iCyc), .iStb(iStb), .iAdr(iAdr), .iDatI(iDatI), .iAck(iAck),
        .dCyc(dCyc), .dStb(dStb), .dWe(dWe), .dAdr(dAdr), .dDatO(dDatO),
        .dDatI(dDatI), .dAck(dAck)
    );

    task automatic stopRun();
        $display("TEST FAIL");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic reportMismatch(input string name, input logic [31:0] exp,
                                  input logic [31:0] act);
        $display("ERROR %s: expected %h, actual %h", name, exp, act);
        stopRun();
    endtask

    task automatic reportProblem(input string text);
        $display("ERROR: %s", text);
        stopRun();
    endtask

    function automatic logic [31:0] encI(int op, int rx, int ry, int imm);
        return {op[4:0], rx[4:0], ry[4:0], imm[16:0]};
    endfunction

    function automatic logic [31:0] encR(int rx, int ry, int rz, int func);
        logic [31:0] w;
        w = '0;
        w[31:27] = OpAlur[4:0]; // Register form opcode
        w[26:22] = rx[4:0];
        w[21:17] = ry[4:0];
        w[16:12] = rz[4:0];
        w[4:0]   = func[4:0];
        return w;
    endfunction

    // Operation rules of the instruction set
    function automatic logic [31:0] ruleResult(int func, logic signed [31:0] a,
                                               logic signed [31:0] b);
        case (func)
            FSub: return a - b;
            FAdd: return a + b;
            FNot: return ~a;
            FAnd: return a & b;
            FOr:  return a | b;
            FXor: return a ^ b;
            FSul, FSsl: return a << b[4:0];
            FSur: return a >> b[4:0];
            FSsr: return a >>> b[4:0];
            FEq:  return (a == b) ? 32'd1 : 32'd0;
            FNeq: return (a != b) ? 32'd1 : 32'd0;
            FLt:  return (a < b) ? 32'd1 : 32'd0;
            FLeq: return (a <= b) ? 32'd1 : 32'd0;
            default: return 32'd0;
        endcase
    endfunction

    function automatic logic [31:0] regValue(int r);
        case (r)
            1: return R1;
            2: return R2;
            3: return R3;
            4: return R4;
            default: return 32'd0;
        endcase
    endfunction

    task automatic emit(input logic [31:0] w);
        prog[progLen] = w;
        progLen++;
    endtask

    task automatic expectStore(input string name, input int off, input logic [31:0] data);
        expName.push_back(name);
        expAdr.push_back(R4 + off);
        expDat.push_back(data);
    endtask

    task automatic buildProgram();
        int          regFuncs [14];
        int          immOps [8];
        int          brOps [4];
        int          brFuncs [4];
        int          brX [8];
        int          brY [8];
        int          slot;
        int          imm;
        int          j;
        logic [31:0] cmp;
        regFuncs = '{FSub, FAdd, FNot, FAnd, FOr, FXor, FSul, FSsl, FSur, FSsr,
                     FEq, FNeq, FLt, FLeq};
        immOps   = '{FAdd, FAnd, FOr, FXor, FSul, FSsl, FSur, FSsr}; // Same codes as op1
        brOps    = '{OpBeq, OpBne, OpBlt, OpBle};
        brFuncs  = '{FEq, FNeq, FLt, FLeq};
        brX      = '{2, 1, 1, 2, 1, 2, 2, 2}; // Taken, not taken per branch
        brY      = '{2, 2, 2, 2, 2, 1, 2, 1};
        slot     = 0;
        for (int i = 0; i < ProgMax; i++) begin
            prog[i] = encI(OpBad, 0, 0, i);
        end
        progLen = 0;
        emit(encI(OpAddi, 0, 1, R1));
        emit(encI(OpAddi, 0, 2, R2));
        emit(encI(OpAddi, 0, 3, R3));
        emit(encI(OpAddi, 0, 4, R4));
        foreach (regFuncs[k]) begin
            emit(encR(1, 2, 5, regFuncs[k]));
            emit(encI(OpSw, 4, 5, slot * 4));
            expectStore($sformatf("register func %0d", regFuncs[k]), slot * 4,
                        ruleResult(regFuncs[k], R1, R2));
            slot++;
        end
        foreach (immOps[k]) begin
            imm = (immOps[k] >= FSul) ? 5 : -3853; // Negative checks sign extension
            emit(encI(immOps[k], 1, 5, imm));
            emit(encI(OpSw, 4, 5, slot * 4));
            expectStore($sformatf("immediate op %0d", immOps[k]), slot * 4,
                        ruleResult(immOps[k], R1, imm));
            slot++;
        end
        // Store, load back, store again
        emit(encI(OpSw, 4, 1, -8));
        expectStore("store before load", -8, R1);
        emit(encI(OpLw, 4, 6, -8));
        emit(encI(OpSw, 4, 6, slot * 4));
        expectStore("store after load", slot * 4, R1);
        slot++;
        // Taken branch skips the fall-through store
        for (int c = 0; c < 8; c++) begin
            cmp = ruleResult(brFuncs[c / 2], regValue(brX[c]), regValue(brY[c]));
            emit(encI(brOps[c / 2], brX[c], brY[c], 1));
            emit(encI(OpSw, 4, 3, slot * 4));
            emit(encI(OpSw, 4, 3, (slot + 1) * 4));
            if (!cmp[0]) begin
                expectStore($sformatf("branch %0d fall-through", c), slot * 4, R3);
            end
            expectStore($sformatf("branch %0d next", c), (slot + 1) * 4, R3);
            slot += 2;
        end
        j = progLen;
        emit(encI(OpAddi, 0, 7, (j + 3) * 4)); // Jump target
        emit(encI(OpJal, 7, 8, 0));
        emit(encI(OpSw, 4, 3, slot * 4));      // Skipped by the jump
        emit(encI(OpSw, 4, 8, (slot + 1) * 4));
        expectStore("jal link", (slot + 1) * 4, (j + 2) * 4);
        haltAdr = progLen * 4;
        emit(encI(OpBad, 0, 0, 0));
    endtask

    task automatic serveData();
        if (dWe) begin
            assert (expAdr.size() > 0) else reportProblem("store with no expected entry");
            assert (dAdr == expAdr[0])
                else reportMismatch({expName[0], " address"}, expAdr[0], dAdr);
            assert (dDatO == expDat[0])
                else reportMismatch({expName[0], " data"}, expDat[0], dDatO);
            dmem[dAdr] = dDatO;
            void'(expName.pop_front());
            void'(expAdr.pop_front());
            void'(expDat.pop_front());
        end else if (dmem.exists(dAdr)) begin
            dDatI = dmem[dAdr];
        end else begin
            dDatI = dAdr ^ 32'hc3a5_5a3c; // Unwritten words
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Instruction memory, one wait state per fetch
    initial begin : instrModel
        logic waitDone;
        iAck     = 1'b0;
        iDatI    = '0;
        waitDone = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            if (iAck) begin
                iAck = 1'b0;
            end else if (iCyc && iStb) begin
                if (!waitDone) begin
                    waitDone = 1'b1; // Ack held off for one cycle
                end else begin
                    waitDone = 1'b0;
                    assert (iAdr < ProgMax * 4) else reportProblem("fetch outside the program");
                    iDatI = prog[iAdr[8:2]];
                    iAck  = 1'b1;
                    if (iAdr == haltAdr) haltSeen = 1'b1;
                end
            end
        end
    end

    // Data memory with 0 to 3 random wait cycles
    initial begin : dataModel
        int   waitCnt;
        logic busy;
        dAck    = 1'b0;
        dDatI   = '0;
        busy    = 1'b0;
        waitCnt = 0;
        forever begin
            @(posedge clk);
            #1;
            if (dAck) begin
                dAck = 1'b0;
            end else if (dCyc && dStb) begin
                if (!busy) begin
                    waitCnt = $unsigned($random(seed)) % 4;
                    busy    = 1'b1;
                end
                if (waitCnt > 0) begin
                    waitCnt--;
                end else begin
                    busy = 1'b0;
                    serveData();
                    dAck = 1'b1;
                end
            end
        end
    end

    initial begin : watchdog
        wait (built);
        #(progLen * 12 * 100);
        reportProblem("watchdog expired before the core halted");
    end

    initial begin
        reset    = 1'b1;
        haltSeen = 1'b0;
        built    = 1'b0;
        buildProgram();
        built = 1'b1;
        repeat (3) @(posedge clk);
        #1 reset = 1'b0;
        wait (haltSeen);
        repeat (2) @(posedge clk);
        // Unknown opcode, no further fetch
        repeat (20) begin
            @(posedge clk);
            #2;
            assert (!iCyc) else reportProblem("fetch issued after an unknown opcode");
        end
        if (expAdr.size() == 0) begin
            $display("TEST PASS");
            $finish;
        end else begin
            reportProblem($sformatf("%0d expected stores never happened", expAdr.size()));
        end
    end

endmodule

/* list.f */
+incdir+hdl
hdl/niuPkg.sv
hdl/niuIf.sv
hdl/instrFetch.sv
hdl/niuAlu.sv
hdl/niuDatapath.sv
hdl/niuControl.sv
hdl/loadStore.sv
hdl/niuCore.sv
tb/niuCore_chk.sv
tb/niuCoreTb.sv

/* run.sh */
#!/bin/sh
# Build and run the niuCore testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module niuCoreTb -o niuSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/niuSim > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
fi

if grep -q "^TEST PASS$" sim.log; then
    exit 0
fi
exit 1
